/* files.f */
+incdir+include
src/or1k_isa_pkg.sv
src/dex_pipe_pkg.sv
src/dex_hazard_detect.sv
src/dex_branch_resolve.sv
src/dex_ctrl_regs.sv
src/dex_payload_regs.sv
src/dex_top.sv
testbench/dex_assertions.sv
testbench/tb_dex_top.sv

/* testbench/tb_dex_top.sv */
`include "dex_cfg.svh"

module tb_dex_top;

   localparam int RESET_CYCLES = 2;
   localparam int PASS_CYCLES = 30;
   localparam int FLUSH_CYCLES = 9;
   localparam int BUBBLE_CYCLES = 7;
   localparam int BRANCH_CYCLES = 20;
   localparam int JR_CYCLES = 24;
   // each test also spends two cycles on its closing line
   localparam int TEST_CYCLES = RESET_CYCLES + PASS_CYCLES + FLUSH_CYCLES + BUBBLE_CYCLES +
                                BRANCH_CYCLES + JR_CYCLES + 5 * 2;
   localparam int MAX_CYCLES = 2 * TEST_CYCLES;
   localparam or1k_isa_pkg::operand_t LINK = `DEX_LINK_OFFSET;

   logic                         clk = 1'b0;
   logic                         rst;
   logic                         padv;
   logic                         flush;
   or1k_isa_pkg::operand_t       pc;
   dex_pipe_pkg::decode_bundle_t dec;
   dex_pipe_pkg::except_t        dec_exc;
   dex_pipe_pkg::ctrl_state_t    ctrl;
   or1k_isa_pkg::operand_t       dec_rfb;
   or1k_isa_pkg::operand_t       exe_rfb;
   logic                         pred;
   dex_pipe_pkg::exec_ctrl_t     exe_ctrl;
   dex_pipe_pkg::exec_data_t     exe_data;
   dex_pipe_pkg::except_t        exe_exc;
   logic                         br;
   or1k_isa_pkg::operand_t       br_target;
   logic                         dec_bubble;
   logic                         exe_bubble;
   logic                         dec_valid;

   // shadow copy of the execute registers
   dex_pipe_pkg::exec_ctrl_t exp_ctrl;
   dex_pipe_pkg::exec_data_t exp_data;
   dex_pipe_pkg::except_t    exp_exc;
   logic                     exp_exe_bubble;
   logic                     exp_valid;
   logic                     data_known = 1'b0;
   logic                     pred_known = 1'b0;

   // expected decode side results of the current cycle
   logic                     exp_bubble;
   logic                     exp_branch;
   logic                     imm_taken;
   logic                     jr_ok;
   or1k_isa_pkg::operand_t   imm_tgt;
   or1k_isa_pkg::operand_t   exp_target;
   or1k_isa_pkg::operand_t   exp_mis;
   dex_pipe_pkg::exec_data_t act_d;
   dex_pipe_pkg::exec_data_t cmp_d;

   logic [31:0] rng = 32'h693a;
   int          errors = 0;
   int          tests_run = 0;
   int          cycles_checked = 0;
   int          test_start_errors = 0;
   int          cycle_count = 0;
   int          total_errors;
   string       cur_test = "reset";

   dex_top dut_i (
      .clk                    (clk),
      .rst                    (rst),
      .padv_i                 (padv),
      .pipeline_flush_i       (flush),
      .pc_decode_i            (pc),
      .decode_i               (dec),
      .decode_except_i        (dec_exc),
      .ctrl_i                 (ctrl),
      .decode_rfb_i           (dec_rfb),
      .execute_rfb_i          (exe_rfb),
      .predicted_flag_i       (pred),
      .execute_ctrl_o         (exe_ctrl),
      .execute_data_o         (exe_data),
      .execute_except_o       (exe_exc),
      .decode_branch_o        (br),
      .decode_branch_target_o (br_target),
      .decode_bubble_o        (dec_bubble),
      .execute_bubble_o       (exe_bubble),
      .decode_valid_o         (dec_valid)
   );

   always #5 clk = ~clk;

   function automatic logic [31:0] next_random();
      rng ^= rng << 13;
      rng ^= rng >> 17;
      rng ^= rng << 5;
      return rng;
   endfunction

   function automatic dex_pipe_pkg::exec_ctrl_t nop_ctrl();
      dex_pipe_pkg::exec_ctrl_t c;
      c = '0;
      c.opc_insn = or1k_isa_pkg::OPC_NOP;
      return c;
   endfunction

   // j and jal always jump, bf/bnf jump when opcode bit 2 equals the flag
   function automatic logic imm_branch_taken(input or1k_isa_pkg::opcode_t opc, input logic flag);
      if (opc[2:1] == 2'b00)
         return 1'b1;
      return opc[2] == flag;
   endfunction

   function automatic or1k_isa_pkg::operand_t imm_branch_target(
      input or1k_isa_pkg::operand_t pc_val,
      input or1k_isa_pkg::jbr_upper_t upper,
      input or1k_isa_pkg::imm16_t imm);
      int disp;
      disp = int'($signed({upper, imm}));
      return pc_val + or1k_isa_pkg::operand_t'(disp * 4);
   endfunction

   function automatic logic jr_clear(input dex_pipe_pkg::decode_bundle_t d,
                                     input dex_pipe_pkg::ctrl_state_t c,
                                     input dex_pipe_pkg::exec_ctrl_t ex,
                                     input or1k_isa_pkg::rf_adr_t ex_rfd);
      logic ctrl_hold;
      ctrl_hold = (c.lsu_load || c.mfspr) &&
                  (d.rfa_adr == c.rfd_adr || d.rfb_adr == c.rfd_adr);
      if (!d.op.jr)
         return 1'b1;
      return !(ctrl_hold || (ex.rf_wb && d.rfb_adr == ex_rfd));
   endfunction

   function automatic logic bubble_expected(input logic adv,
                                            input dex_pipe_pkg::decode_bundle_t d,
                                            input dex_pipe_pkg::ctrl_state_t c,
                                            input dex_pipe_pkg::exec_ctrl_t ex,
                                            input or1k_isa_pkg::rf_adr_t ex_rfd);
      logic load_use;
      logic atomic;
      load_use = (ex.op.lsu_load || ex.op.mfspr) &&
                 (d.rfa_adr == ex_rfd || d.rfb_adr == ex_rfd);
      atomic = ex.op.lsu_store && ex.op.lsu_atomic;
      return adv && (load_use || !jr_clear(d, c, ex, ex_rfd) || atomic || d.rfe);
   endfunction

   task automatic report_mismatch(input string what, input logic [255:0] expected,
                                  input logic [255:0] actual);
      errors++;
      $display("[FAIL] %s %s: expected %h actual %h", cur_test, what, expected, actual);
   endtask

   // compare at the falling edge, then step the shadow registers
   always @(negedge clk) begin
      jr_ok = jr_clear(dec, ctrl, exp_ctrl, exp_data.rfd_adr);
      exp_bubble = bubble_expected(padv, dec, ctrl, exp_ctrl, exp_data.rfd_adr);
      imm_taken = dec.op.jbr && imm_branch_taken(dec.opc_insn, pred);
      imm_tgt = imm_branch_target(pc, dec.immjbr_upper, dec.imm16);
      if (imm_taken) begin
         exp_target = imm_tgt;
      end else if (exp_exe_bubble || exp_ctrl.op.jr) begin
         exp_target = exe_rfb;
      end else begin
         exp_target = dec_rfb;
      end
      exp_branch = (imm_taken || (dec.op.jr && jr_ok)) && !flush;
      if ((dec.op.bf && !pred) || (dec.op.bnf && pred)) begin
         exp_mis = imm_tgt;
      end else begin
         exp_mis = pc + LINK;
      end

      if (!rst) begin
         cycles_checked++;
         if (dec_bubble !== exp_bubble)
            report_mismatch("decode_bubble", exp_bubble, dec_bubble);
         if (br !== exp_branch)
            report_mismatch("decode_branch", exp_branch, br);
         if (br_target !== exp_target)
            report_mismatch("branch_target", exp_target, br_target);
         if (exe_ctrl !== exp_ctrl)
            report_mismatch("execute_ctrl", exp_ctrl, exe_ctrl);
         if (exe_bubble !== exp_exe_bubble)
            report_mismatch("execute_bubble", exp_exe_bubble, exe_bubble);
         if (dec_valid !== exp_valid)
            report_mismatch("decode_valid", exp_valid, dec_valid);
         if (exe_exc !== exp_exc)
            report_mismatch("execute_except", exp_exc, exe_exc);
         act_d = exe_data;
         cmp_d = exp_data;
         // prediction fields stay unknown until the first conditional branch
         if (!pred_known) begin
            act_d.mispredict_target = '0;
            act_d.predicted_flag = 1'b0;
            cmp_d.mispredict_target = '0;
            cmp_d.predicted_flag = 1'b0;
         end
         if (data_known && act_d !== cmp_d)
            report_mismatch("execute_data", cmp_d, act_d);
      end

      if (padv) begin
         exp_data.rfd_adr = dec.rfd_adr;
         exp_data.imm16 = dec.imm16;
         exp_data.immediate = dec.immediate;
         exp_data.immediate_sel = dec.immediate_sel;
         exp_data.immjbr_upper = dec.immjbr_upper;
         exp_data.opc_alu = dec.opc_alu;
         exp_data.opc_alu_secondary = dec.opc_alu_secondary;
         exp_data.lsu_length = dec.lsu_length;
         exp_data.lsu_zext = dec.lsu_zext;
         exp_data.pc = pc;
         exp_data.jal_result = pc + LINK;
         data_known = 1'b1;
         if (dec.op.brcond) begin
            exp_data.mispredict_target = exp_mis;
            exp_data.predicted_flag = pred;
            pred_known = 1'b1;
         end
      end
      if (rst) begin
         exp_ctrl = nop_ctrl();
         exp_exe_bubble = 1'b0;
         exp_valid = 1'b0;
         exp_exc = '0;
      end else begin
         exp_valid = padv;
         if (padv) begin
            exp_exc = dec_exc;
            exp_exc.ibus_align = exp_branch && (exp_target[1:0] != 2'b00);
         end
         if (flush) begin
            exp_ctrl = nop_ctrl();
            exp_exe_bubble = 1'b0;
         end else if (padv) begin
            if (exp_bubble) begin
               exp_ctrl = nop_ctrl();
            end else begin
               exp_ctrl.op = dec.op;
               exp_ctrl.adder = dec.adder;
               exp_ctrl.rf_wb = dec.rf_wb;
               exp_ctrl.opc_insn = dec.opc_insn;
            end
            // rfe travels on even inside a bubble
            exp_ctrl.rfe = dec.rfe;
            exp_exe_bubble = exp_bubble;
         end
      end
   end

   always @(posedge clk) begin
      cycle_count++;
      if (cycle_count >= MAX_CYCLES) begin
         $display("timeout: tests still running after %0d cycles", cycle_count);
         $display("Errors found");
         $finish;
      end
   end

   task automatic tick();
      @(posedge clk);
      #1;
   endtask

   // random bundle with no load, mfspr, store, jr or rfe
   task automatic drive_random(input logic adv);
      logic [127:0] raw;
      logic [31:0]  r;
      raw = {next_random(), next_random(), next_random(), next_random()};
      r = next_random();
      dec = raw[$bits(dex_pipe_pkg::decode_bundle_t)-1:0];
      dec.op.lsu_load = 1'b0;
      dec.op.mfspr = 1'b0;
      dec.op.lsu_store = 1'b0;
      dec.op.lsu_atomic = 1'b0;
      dec.op.jr = 1'b0;
      dec.rfe = 1'b0;
      dec_exc = r[6:0];
      ctrl = r[13:7];
      ctrl.lsu_load = 1'b0;
      ctrl.mfspr = 1'b0;
      pred = r[14];
      padv = adv;
      pc = next_random();
      dec_rfb = next_random();
      exe_rfb = next_random();
   endtask

   task automatic begin_test(input string name);
      cur_test = name;
      test_start_errors = errors;
   endtask

   task automatic end_test();
      @(negedge clk);
      #1;
      tests_run++;
      $display("test %s done, %0d errors", cur_test, errors - test_start_errors);
      tick();
   endtask

   task automatic run_pass_through();
      logic [31:0] r;
      begin_test("pass_through");
      for (int i = 0; i < PASS_CYCLES; i++) begin
         r = next_random();
         drive_random(r[1:0] != 2'b00);
         tick();
      end
      end_test();
   endtask

   task automatic run_flush();
      begin_test("flush");
      for (int i = 0; i < 3; i++) begin
         drive_random(1'b1);
         tick();
      end
      // exceptions must hold through a flush without padv
      flush = 1'b1;
      padv = 1'b0;
      tick();
      padv = 1'b1;
      tick();
      flush = 1'b0;
      drive_random(1'b1);
      tick();
      // rfe bubble in execute, then a flush while decode still bubbles
      drive_random(1'b1);
      dec.rfe = 1'b1;
      tick();
      flush = 1'b1;
      tick();
      flush = 1'b0;
      drive_random(1'b1);
      tick();
      end_test();
   endtask

   task automatic run_bubbles();
      begin_test("bubbles");
      drive_random(1'b1);
      dec.op.lsu_load = 1'b1;
      dec.rf_wb = 1'b1;
      dec.rfd_adr = 5'd7;
      tick();
      drive_random(1'b1);
      dec.rfa_adr = 5'd7;
      tick();
      drive_random(1'b1);
      dec.op.lsu_store = 1'b1;
      dec.op.lsu_atomic = 1'b1;
      tick();
      drive_random(1'b1);
      tick();
      drive_random(1'b1);
      dec.rfe = 1'b1;
      tick();
      drive_random(1'b1);
      tick();
      padv = 1'b0;
      tick();
      end_test();
   endtask

   task automatic run_imm_branches();
      logic [31:0] r;
      begin_test("imm_branches");
      for (int i = 0; i < BRANCH_CYCLES; i++) begin
         drive_random(1'b1);
         r = next_random();
         case (r[1:0])
            2'd0: dec.opc_insn = or1k_isa_pkg::OPC_J;
            2'd1: dec.opc_insn = or1k_isa_pkg::OPC_JAL;
            2'd2: dec.opc_insn = or1k_isa_pkg::OPC_BNF;
            default: dec.opc_insn = or1k_isa_pkg::OPC_BF;
         endcase
         dec.op.jbr = 1'b1;
         dec.op.jal = dec.opc_insn == or1k_isa_pkg::OPC_JAL;
         dec.op.bf = dec.opc_insn == or1k_isa_pkg::OPC_BF;
         dec.op.bnf = dec.opc_insn == or1k_isa_pkg::OPC_BNF;
         dec.op.brcond = dec.op.bf | dec.op.bnf;
         pred = r[2];
         tick();
      end
      end_test();
   endtask

   // few register numbers so that interlocks hit often
   task automatic run_reg_branches();
      logic [31:0] r;
      begin_test("reg_branches");
      for (int i = 0; i < JR_CYCLES; i++) begin
         drive_random(1'b1);
         r = next_random();
         dec.op.jr = r[0];
         dec.op.jbr = 1'b0;
         dec.rfa_adr = {3'b000, r[2:1]};
         dec.rfb_adr = {3'b000, r[4:3]};
         dec.rfd_adr = {3'b000, r[6:5]};
         dec.rf_wb = r[7];
         dec.rfe = r[10:8] == 3'b000;
         dec.op.lsu_load = r[13:11] == 3'b000;
         dec.op.mfspr = r[24:22] == 3'b000;
         ctrl.lsu_load = r[14];
         ctrl.mfspr = r[21:20] == 2'b00;
         ctrl.rfd_adr = {3'b000, r[16:15]};
         padv = r[19:17] != 3'b000;
         tick();
      end
      end_test();
   endtask

   initial begin
      rst = 1'b1;
      padv = 1'b0;
      flush = 1'b0;
      pc = '0;
      dec = '0;
      dec_exc = '0;
      ctrl = '0;
      dec_rfb = '0;
      exe_rfb = '0;
      pred = 1'b0;
      repeat (RESET_CYCLES) tick();
      rst = 1'b0;
      run_pass_through();
      run_flush();
      run_bubbles();
      run_imm_branches();
      run_reg_branches();
      total_errors = errors + dut_i.assert_i.fail_count;
      $display("tests %0d, cycles checked %0d, errors %0d", tests_run, cycles_checked,
               total_errors);
      if (total_errors == 0) begin
         $display("No errors");
      end else begin
         $display("Errors found");
      end
      $finish;
   end

endmodule

/* testbench/dex_assertions.sv */
module dex_assertions (
   input logic                     clk,
   input logic                     rst,
   input logic                     padv_i,
   input logic                     pipeline_flush_i,
   input dex_pipe_pkg::exec_ctrl_t execute_ctrl_i,
   input logic                     execute_bubble_i,
   input logic                     decode_bubble_i,
   input logic                     decode_valid_i
);

   // read by the testbench for its final count
   int fail_count = 0;

   // a flushed execute stage holds a nop at the next edge
   flush_clears_ctrl: assert property (@(posedge clk) disable iff (rst)
      pipeline_flush_i |=> (execute_ctrl_i.op == '0 && !execute_ctrl_i.rfe &&
                            !execute_ctrl_i.rf_wb && !execute_bubble_i &&
                            execute_ctrl_i.opc_insn == or1k_isa_pkg::OPC_NOP))
      else begin
         $error("flush did not clear the execute control at the next edge");
         fail_count++;
      end

   bubble_needs_padv: assert property (@(posedge clk) disable iff (rst)
      decode_bubble_i |-> padv_i)
      else begin
         $error("decode bubble raised without padv");
         fail_count++;
      end

   valid_follows_padv: assert property (@(posedge clk) disable iff (rst)
      1'b1 |=> (decode_valid_i == $past(padv_i)))
      else begin
         $error("decode valid is not padv delayed by one cycle");
         fail_count++;
      end

endmodule

bind dex_top dex_assertions assert_i (
   .clk              (clk),
   .rst              (rst),
   .padv_i           (padv_i),
   .pipeline_flush_i (pipeline_flush_i),
   .execute_ctrl_i   (execute_ctrl_o),
   .execute_bubble_i (execute_bubble_o),
   .decode_bubble_i  (decode_bubble_o),
   .decode_valid_i   (decode_valid_o)
);

/* src/dex_top.sv */
module dex_top (
   input  logic                         clk,
   input  logic                         rst,
   input  logic                         padv_i,
   input  logic                         pipeline_flush_i,
   input  or1k_isa_pkg::operand_t       pc_decode_i,
   input  dex_pipe_pkg::decode_bundle_t decode_i,
   input  dex_pipe_pkg::except_t        decode_except_i,
   input  dex_pipe_pkg::ctrl_state_t    ctrl_i,
   input  or1k_isa_pkg::operand_t       decode_rfb_i,
   input  or1k_isa_pkg::operand_t       execute_rfb_i,
   input  logic                         predicted_flag_i,
   output dex_pipe_pkg::exec_ctrl_t     execute_ctrl_o,
   output dex_pipe_pkg::exec_data_t     execute_data_o,
   output dex_pipe_pkg::except_t        execute_except_o,
   output logic                         decode_branch_o,
   output or1k_isa_pkg::operand_t       decode_branch_target_o,
   output logic                         decode_bubble_o,
   output logic                         execute_bubble_o,
   output logic                         decode_valid_o
);

   logic                     jr_ready;
   logic                     target_misaligned;
   or1k_isa_pkg::operand_t   mispredict_target;
   or1k_isa_pkg::operand_t   link_pc;
   dex_pipe_pkg::exec_ctrl_t exec_ctrl;
   dex_pipe_pkg::exec_data_t exec_data;

   // interlocks against execute and control stage results
   dex_hazard_detect u_hazard (
      .padv_i            (padv_i),
      .decode_i          (decode_i),
      .execute_ctrl_i    (exec_ctrl),
      .execute_rfd_adr_i (exec_data.rfd_adr),
      .ctrl_i            (ctrl_i),
      .decode_bubble_o   (decode_bubble_o),
      .jr_ready_o        (jr_ready)
   );

   // branches resolve while still in decode
   dex_branch_resolve u_branch (
      .decode_i            (decode_i),
      .pc_decode_i         (pc_decode_i),
      .predicted_flag_i    (predicted_flag_i),
      .pipeline_flush_i    (pipeline_flush_i),
      .jr_ready_i          (jr_ready),
      .execute_bubble_i    (execute_bubble_o),
      .execute_jr_i        (exec_ctrl.op.jr),
      .decode_rfb_i        (decode_rfb_i),
      .execute_rfb_i       (execute_rfb_i),
      .branch_o            (decode_branch_o),
      .branch_target_o     (decode_branch_target_o),
      .target_misaligned_o (target_misaligned),
      .mispredict_target_o (mispredict_target),
      .link_pc_o           (link_pc)
   );

   dex_ctrl_regs u_ctrl (
      .clk              (clk),
      .rst              (rst),
      .padv_i           (padv_i),
      .pipeline_flush_i (pipeline_flush_i),
      .decode_i         (decode_i),
      .decode_bubble_i  (decode_bubble_o),
      .execute_ctrl_o   (exec_ctrl),
      .execute_bubble_o (execute_bubble_o),
      .decode_valid_o   (decode_valid_o)
   );

   dex_payload_regs u_payload (
      .clk                 (clk),
      .rst                 (rst),
      .padv_i              (padv_i),
      .decode_i            (decode_i),
      .pc_decode_i         (pc_decode_i),
      .decode_except_i     (decode_except_i),
      .target_misaligned_i (target_misaligned),
      .predicted_flag_i    (predicted_flag_i),
      .mispredict_target_i (mispredict_target),
      .link_pc_i           (link_pc),
      .execute_data_o      (exec_data),
      .execute_except_o    (execute_except_o)
   );

   assign execute_ctrl_o = exec_ctrl;
   assign execute_data_o = exec_data;

endmodule

/* src/dex_payload_regs.sv */
module dex_payload_regs (
   input  logic                         clk,
   input  logic                         rst,
   input  logic                         padv_i,
   input  dex_pipe_pkg::decode_bundle_t decode_i,
   input  or1k_isa_pkg::operand_t       pc_decode_i,
   input  dex_pipe_pkg::except_t        decode_except_i,
   input  logic                         target_misaligned_i,
   input  logic                         predicted_flag_i,
   input  or1k_isa_pkg::operand_t       mispredict_target_i,
   input  or1k_isa_pkg::operand_t       link_pc_i,
   output dex_pipe_pkg::exec_data_t     execute_data_o,
   output dex_pipe_pkg::except_t        execute_except_o
);

   dex_pipe_pkg::exec_data_t data_q;
   dex_pipe_pkg::except_t    except_q;
   dex_pipe_pkg::except_t    except_next;

   always_ff @(posedge clk) begin
      if (padv_i) begin
         data_q.rfd_adr           <= decode_i.rfd_adr;
         data_q.imm16             <= decode_i.imm16;
         data_q.immediate         <= decode_i.immediate;
         data_q.immediate_sel     <= decode_i.immediate_sel;
         data_q.immjbr_upper      <= decode_i.immjbr_upper;
         data_q.opc_alu           <= decode_i.opc_alu;
         data_q.opc_alu_secondary <= decode_i.opc_alu_secondary;
         data_q.lsu_length        <= decode_i.lsu_length;
         data_q.lsu_zext          <= decode_i.lsu_zext;
         data_q.pc                <= pc_decode_i;
         data_q.jal_result        <= link_pc_i;
         // prediction info only matters for conditional branches
         if (decode_i.op.brcond) begin
            data_q.mispredict_target <= mispredict_target_i;
            data_q.predicted_flag    <= predicted_flag_i;
         end
      end
   end

   // alignment of the branch target is checked here, not by fetch
   always_comb begin
      except_next            = decode_except_i;
      except_next.ibus_align = target_misaligned_i;
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         except_q <= '0;
      end else if (padv_i) begin
         except_q <= except_next;
      end
   end

   assign execute_data_o   = data_q;
   assign execute_except_o = except_q;

endmodule

/* src/dex_ctrl_regs.sv */
module dex_ctrl_regs (
   input  logic                         clk,
   input  logic                         rst,
   input  logic                         padv_i,
   input  logic                         pipeline_flush_i,
   input  dex_pipe_pkg::decode_bundle_t decode_i,
   input  logic                         decode_bubble_i,
   output dex_pipe_pkg::exec_ctrl_t     execute_ctrl_o,
   output logic                         execute_bubble_o,
   output logic                         decode_valid_o
);

   dex_pipe_pkg::exec_ctrl_t ctrl_q;
   dex_pipe_pkg::exec_ctrl_t ctrl_idle;
   dex_pipe_pkg::exec_ctrl_t ctrl_next;
   logic                     bubble_q;
   logic                     valid_q;

   // nop state used by reset, flush and bubble
   always_comb begin
      ctrl_idle          = '0;
      ctrl_idle.opc_insn = or1k_isa_pkg::OPC_NOP;
   end

   always_comb begin
      if (decode_bubble_i) begin
         ctrl_next = ctrl_idle;
      end else begin
         ctrl_next.op       = decode_i.op;
         ctrl_next.adder    = decode_i.adder;
         ctrl_next.rf_wb    = decode_i.rf_wb;
         ctrl_next.opc_insn = decode_i.opc_insn;
      end
      // rfe keeps going through the bubble until it reaches control
      // and flushes the pipe itself
      ctrl_next.rfe = decode_i.rfe;
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         ctrl_q <= ctrl_idle;
      end else if (pipeline_flush_i) begin
         ctrl_q <= ctrl_idle;
      end else if (padv_i) begin
         ctrl_q <= ctrl_next;
      end
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         bubble_q <= 1'b0;
      end else if (pipeline_flush_i) begin
         bubble_q <= 1'b0;
      end else if (padv_i) begin
         bubble_q <= decode_bubble_i;
      end
   end

   // stage done one cycle after an advance
   always_ff @(posedge clk) begin
      if (rst) begin
         valid_q <= 1'b0;
      end else begin
         valid_q <= padv_i;
      end
   end

   assign execute_ctrl_o   = ctrl_q;
   assign execute_bubble_o = bubble_q;
   assign decode_valid_o   = valid_q;

endmodule

/* src/dex_branch_resolve.sv */
`include "dex_cfg.svh"

module dex_branch_resolve (
   input  dex_pipe_pkg::decode_bundle_t decode_i,
   input  or1k_isa_pkg::operand_t       pc_decode_i,
   input  logic                         predicted_flag_i,
   input  logic                         pipeline_flush_i,
   input  logic                         jr_ready_i,
   input  logic                         execute_bubble_i,
   input  logic                         execute_jr_i,
   input  or1k_isa_pkg::operand_t       decode_rfb_i,
   input  or1k_isa_pkg::operand_t       execute_rfb_i,
   output logic                         branch_o,
   output or1k_isa_pkg::operand_t       branch_target_o,
   output logic                         target_misaligned_o,
   output or1k_isa_pkg::operand_t       mispredict_target_o,
   output or1k_isa_pkg::operand_t       link_pc_o
);

   // sign bits needed above upper, imm16 and the two word offset bits
   localparam int SEXT_W = `DEX_OPERAND_WIDTH - `DEX_JBR_UPPER_WIDTH -
                           `DEX_IMM_WIDTH - 2;

   logic                   is_jump;
   logic                   flag_match;
   logic                   branch_to_imm;
   logic                   branch_to_reg;
   logic                   bf_mispredict;
   or1k_isa_pkg::operand_t imm_offset;
   or1k_isa_pkg::operand_t imm_target;
   or1k_isa_pkg::operand_t reg_target;

   // l.j and l.jal
   assign is_jump = ~(|decode_i.opc_insn[2:1]);

   // l.bf/l.bnf taken when the predicted flag matches opcode bit 2
   assign flag_match = decode_i.opc_insn[2] == predicted_flag_i;

   assign branch_to_imm = decode_i.op.jbr & (is_jump | flag_match);

   assign imm_offset = {{SEXT_W{decode_i.immjbr_upper[`DEX_JBR_UPPER_WIDTH-1]}},
                        decode_i.immjbr_upper,
                        decode_i.imm16,
                        2'b00};

   assign imm_target = pc_decode_i + imm_offset;

   assign branch_to_reg = decode_i.op.jr & jr_ready_i;

   // after a bubble the producer of rfb has moved on, take the value
   // from the execute stage bypass
   assign reg_target = (execute_bubble_i | execute_jr_i) ? execute_rfb_i : decode_rfb_i;

   assign branch_o = (branch_to_imm | branch_to_reg) & ~pipeline_flush_i;

   assign branch_target_o = branch_to_imm ? imm_target : reg_target;

   assign target_misaligned_o = branch_o & (|branch_target_o[1:0]);

   assign link_pc_o = pc_decode_i + or1k_isa_pkg::operand_t'(`DEX_LINK_OFFSET);

   // predicted not taken, so the real target is the branch target
   assign bf_mispredict = (decode_i.op.bf & ~predicted_flag_i) |
                          (decode_i.op.bnf & predicted_flag_i);

   assign mispredict_target_o = bf_mispredict ? imm_target : link_pc_o;

endmodule

/* src/dex_hazard_detect.sv */
module dex_hazard_detect (
   input  logic                         padv_i,
   input  dex_pipe_pkg::decode_bundle_t decode_i,
   input  dex_pipe_pkg::exec_ctrl_t     execute_ctrl_i,
   input  or1k_isa_pkg::rf_adr_t        execute_rfd_adr_i,
   input  dex_pipe_pkg::ctrl_state_t    ctrl_i,
   output logic                         decode_bubble_o,
   output logic                         jr_ready_o
);

   logic ctrl_late_result;
   logic ctrl_interlock;
   logic exec_late_result;
   logic exec_operand_hit;
   logic exec_rfb_wb_hit;
   logic load_use;
   logic jr_hazard;
   logic atomic_store;

   // control stage still producing a load or mfspr result
   assign ctrl_late_result = ctrl_i.lsu_load | ctrl_i.mfspr;

   assign ctrl_interlock = ctrl_late_result &
                           ((decode_i.rfa_adr == ctrl_i.rfd_adr) |
                            (decode_i.rfb_adr == ctrl_i.rfd_adr));

   // same kind of instruction one stage earlier, in execute
   assign exec_late_result = execute_ctrl_i.op.lsu_load | execute_ctrl_i.op.mfspr;

   assign exec_operand_hit = (decode_i.rfa_adr == execute_rfd_adr_i) |
                             (decode_i.rfb_adr == execute_rfd_adr_i);

   assign load_use = exec_late_result & exec_operand_hit;

   // jr reads rfb in decode, so any pending write to it blocks the jump
   assign exec_rfb_wb_hit = execute_ctrl_i.rf_wb &
                            (decode_i.rfb_adr == execute_rfd_adr_i);

   assign jr_hazard = decode_i.op.jr & (ctrl_interlock | exec_rfb_wb_hit);

   assign jr_ready_o = ~jr_hazard;

   // atomic store needs an empty slot behind it
   assign atomic_store = execute_ctrl_i.op.lsu_store & execute_ctrl_i.op.lsu_atomic;

   // rfe stalls fetch while it travels up to the control stage
   assign decode_bubble_o = (load_use | jr_hazard | atomic_store | decode_i.rfe) &
                            padv_i;

endmodule

/* src/dex_pipe_pkg.sv */
package dex_pipe_pkg;

   // one strobe per operation class
   typedef struct packed {
      logic alu;
      logic add;
      logic mul;
      logic mul_signed;
      logic mul_unsigned;
      logic div;
      logic div_signed;
      logic div_unsigned;
      logic shift;
      logic ffl1;
      logic movhi;
      logic ext;
      logic msync;
      logic mfspr;
      logic mtspr;
      logic lsu_load;
      logic lsu_store;
      logic lsu_atomic;
      logic setflag;
      logic jbr;
      logic jr;
      logic jal;
      logic brcond;
      logic branch;
      logic bf;
      logic bnf;
   } op_flags_t;

   typedef struct packed {
      logic do_sub;
      logic do_carry;
   } adder_ctl_t;

   // instruction side exceptions
   typedef struct packed {
      logic ibus_err;
      logic itlb_miss;
      logic ipagefault;
      logic illegal;
      logic syscall;
      logic trap;
      logic ibus_align;
   } except_t;

   // everything the decoder hands over
   typedef struct packed {
      op_flags_t               op;
      adder_ctl_t              adder;
      logic                    rfe;
      logic                    rf_wb;
      or1k_isa_pkg::opcode_t    opc_insn;
      or1k_isa_pkg::alu_opc_t   opc_alu;
      or1k_isa_pkg::alu_opc_t   opc_alu_secondary;
      or1k_isa_pkg::imm16_t     imm16;
      or1k_isa_pkg::operand_t   immediate;
      logic                    immediate_sel;
      or1k_isa_pkg::jbr_upper_t immjbr_upper;
      or1k_isa_pkg::rf_adr_t    rfd_adr;
      or1k_isa_pkg::rf_adr_t    rfa_adr;
      or1k_isa_pkg::rf_adr_t    rfb_adr;
      or1k_isa_pkg::lsu_len_t   lsu_length;
      logic                    lsu_zext;
   } decode_bundle_t;

   // the few control stage bits needed for the interlock
   typedef struct packed {
      or1k_isa_pkg::rf_adr_t rfd_adr;
      logic                 lsu_load;
      logic                 mfspr;
   } ctrl_state_t;

   // flushable execute control
   typedef struct packed {
      op_flags_t            op;
      adder_ctl_t           adder;
      logic                 rfe;
      logic                 rf_wb;
      or1k_isa_pkg::opcode_t opc_insn;
   } exec_ctrl_t;

   // execute payload, never flushed
   typedef struct packed {
      or1k_isa_pkg::rf_adr_t    rfd_adr;
      or1k_isa_pkg::imm16_t     imm16;
      or1k_isa_pkg::operand_t   immediate;
      logic                    immediate_sel;
      or1k_isa_pkg::jbr_upper_t immjbr_upper;
      or1k_isa_pkg::alu_opc_t   opc_alu;
      or1k_isa_pkg::alu_opc_t   opc_alu_secondary;
      or1k_isa_pkg::lsu_len_t   lsu_length;
      logic                    lsu_zext;
      or1k_isa_pkg::operand_t   pc;
      or1k_isa_pkg::operand_t   jal_result;
      or1k_isa_pkg::operand_t   mispredict_target;
      logic                    predicted_flag;
   } exec_data_t;

endpackage

/* src/or1k_isa_pkg.sv */
`include "dex_cfg.svh"

package or1k_isa_pkg;

   // data word or address
   typedef logic [`DEX_OPERAND_WIDTH-1:0] operand_t;

   // general purpose register number
   typedef logic [`DEX_RF_ADDR_WIDTH-1:0] rf_adr_t;

   typedef logic [`DEX_OPCODE_WIDTH-1:0] opcode_t;

   typedef logic [`DEX_ALU_OPC_WIDTH-1:0] alu_opc_t;

   typedef logic [`DEX_IMM_WIDTH-1:0] imm16_t;

   // upper displacement bits for l.j, l.jal, l.bf and l.bnf
   typedef logic [`DEX_JBR_UPPER_WIDTH-1:0] jbr_upper_t;

   // load/store access size
   typedef logic [1:0] lsu_len_t;

   // major opcodes
   localparam opcode_t OPC_NOP = 6'h05;

   // unconditional jumps have opcode bits 2:1 clear
   localparam opcode_t OPC_J   = 6'h00;
   localparam opcode_t OPC_JAL = 6'h01;

   // for conditional branches bit 2 is the flag value that takes the branch
   localparam opcode_t OPC_BNF = 6'h03;
   localparam opcode_t OPC_BF  = 6'h04;

endpackage

/* include/dex_cfg.svh */
`ifndef DEX_CFG_SVH
`define DEX_CFG_SVH

// data path and pc width
`define DEX_OPERAND_WIDTH 32

// register file address width
`define DEX_RF_ADDR_WIDTH 5

// major opcode field of the instruction word
`define DEX_OPCODE_WIDTH 6

// alu opcode width, primary and secondary
`define DEX_ALU_OPC_WIDTH 4

// 16-bit immediate field
`define DEX_IMM_WIDTH 16

// upper bits of the jump/branch displacement above imm16
`define DEX_JBR_UPPER_WIDTH 10

// link address skips the delay slot
`define DEX_LINK_OFFSET 8

`endif
